/* dbg_dmi_top.f */
+incdir+include
hdl/dbg_jtag_pkg.sv
hdl/dbg_security_pkg.sv
hdl/dbg_jtag_tap.sv
hdl/dbg_dmi_access.sv
hdl/dbg_access_gate.sv
hdl/dbg_core_regs.sv
hdl/dbg_dmi_top.sv
verif/tb_dbg_dmi_top.sv

/* hdl/dbg_access_gate.sv */
/*
 * Debug access gate: security state latched in reset, core versus
 * uncore aperture routing of enables, read data selection
 */

`timescale 1ns/1ns

module dbg_access_gate
   import dbg_jtag_pkg::*;
   import dbg_security_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  debug_locked,
   input  lifecycle_t            device_lifecycle,
   input  logic                  dmi_reg_en,
   input  logic                  dmi_reg_wr_en,
   input  logic [DMI_ADDR_W-1:0] dmi_reg_addr,
   input  logic [DMI_DATA_W-1:0] core_reg_rdata,
   input  logic [DMI_DATA_W-1:0] uncore_dmi_reg_rdata,
   output logic                  core_reg_en,
   output logic                  core_reg_wr_en,
   output logic                  uncore_dmi_reg_en,
   output logic                  uncore_dmi_reg_wr_en,
   output logic                  dmi_reg_en_pre,
   output logic [DMI_DATA_W-1:0] dmi_reg_rdata
);

   logic access_allowed;
   logic uncore_aperture;
   logic en_allowed;
   logic wr_en_allowed;

   //*************************************************
   // Security latch
   //*************************************************

   // Tracks the inputs only while rst is high, frozen afterwards
   always_ff @(posedge clk) begin
      if (rst) begin
         access_allowed <= !debug_locked || (device_lifecycle == DEVICE_MANUFACTURING);
      end
   end

   //*************************************************
   // Aperture routing
   //*************************************************

   assign uncore_aperture = (dmi_reg_addr >= UNCORE_APERTURE_BASE);

   assign en_allowed    = dmi_reg_en & access_allowed;
   assign wr_en_allowed = dmi_reg_wr_en & access_allowed;

   assign core_reg_en          = en_allowed & ~uncore_aperture;
   assign core_reg_wr_en       = wr_en_allowed & ~uncore_aperture;
   assign uncore_dmi_reg_en    = en_allowed & uncore_aperture;
   assign uncore_dmi_reg_wr_en = wr_en_allowed & uncore_aperture;

   assign dmi_reg_en_pre = dmi_reg_en;   // Ungated, for observation

   // Blocked reads return zero
   always_comb begin
      if (!access_allowed) begin
         dmi_reg_rdata = '0;
      end else if (uncore_aperture) begin
         dmi_reg_rdata = uncore_dmi_reg_rdata;
      end else begin
         dmi_reg_rdata = core_reg_rdata;
      end
   end

endmodule

/* hdl/dbg_core_regs.sv */
/*
 * Core-side DMI register file standing in for the processor's
 * debug module registers
 */

`timescale 1ns/1ns

module dbg_core_regs
   import dbg_jtag_pkg::*;
#(
   parameter int CORE_REG_COUNT = 16
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  core_reg_en,
   input  logic                  core_reg_wr_en,
   input  logic [DMI_ADDR_W-1:0] dmi_reg_addr,
   input  logic [DMI_DATA_W-1:0] dmi_reg_wdata,
   output logic [DMI_DATA_W-1:0] core_reg_rdata
);

   localparam int IDX_W = (CORE_REG_COUNT > 1) ? $clog2(CORE_REG_COUNT) : 1;

   logic [DMI_DATA_W-1:0] regs [CORE_REG_COUNT];
   logic [IDX_W-1:0]      reg_idx;
   logic                  reg_hit;

   assign reg_idx = IDX_W'(dmi_reg_addr);
   assign reg_hit = (int'(dmi_reg_addr) < CORE_REG_COUNT);   // Rest of core aperture is empty

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < CORE_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (core_reg_en && core_reg_wr_en && reg_hit) begin
         regs[reg_idx] <= dmi_reg_wdata;
      end
   end

   // Combinational read, gate samples it in the enable cycle
   always_comb begin
      if (reg_hit) begin
         core_reg_rdata = regs[reg_idx];
      end else begin
         core_reg_rdata = '0;
      end
   end

endmodule

/* hdl/dbg_dmi_access.sv */
/*
 * DMI access stage: turns a completed DMI scan into one
 * register-bus pulse and holds read data for the next capture
 */

`timescale 1ns/1ns

module dbg_dmi_access
   import dbg_jtag_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  dmi_update,
   input  logic [DMI_ADDR_W-1:0] dmi_scan_addr,
   input  logic [DMI_DATA_W-1:0] dmi_scan_data,
   input  dmi_op_t               dmi_scan_op,
   input  logic [DMI_DATA_W-1:0] dmi_reg_rdata,
   output logic                  dmi_reg_en,
   output logic                  dmi_reg_wr_en,
   output logic [DMI_ADDR_W-1:0] dmi_reg_addr,
   output logic [DMI_DATA_W-1:0] dmi_reg_wdata,
   output logic [DMI_SCAN_W-1:0] dmi_capture_word
);

   logic [DMI_DATA_W-1:0] rd_data_q;

   // Request stage, one pulse per read or write
   always_ff @(posedge clk) begin
      if (rst) begin
         dmi_reg_en    <= 1'b0;
         dmi_reg_wr_en <= 1'b0;
         dmi_reg_addr  <= '0;
      end else begin
         dmi_reg_en    <= dmi_update && (dmi_scan_op inside {DMI_READ, DMI_WRITE});
         dmi_reg_wr_en <= dmi_update && (dmi_scan_op == DMI_WRITE);
         if (dmi_update) begin
            dmi_reg_addr <= dmi_scan_addr;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dmi_update) begin
         dmi_reg_wdata <= dmi_scan_data;
      end
   end

   // Read response, bus completes within the pulse cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_data_q <= '0;
      end else if (dmi_reg_en && !dmi_reg_wr_en) begin
         rd_data_q <= dmi_reg_rdata;
      end
   end

   // Status field always 0, no busy or error reporting
   assign dmi_capture_word = {dmi_reg_addr, rd_data_q, DMI_OP_W'(0)};

endmodule

/* hdl/dbg_dmi_top.sv */
/*
 * Debug access top level: JTAG TAP, DMI access stage,
 * security gate and core-side register file
 */

`timescale 1ns/1ns

module dbg_dmi_top
   import dbg_jtag_pkg::*;
   import dbg_security_pkg::*;
#(
   parameter logic [31:0] IDCODE         = 32'h1000_0cd3,
   parameter int          CORE_REG_COUNT = 16
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  jtag_tck,
   input  logic                  jtag_tms,
   input  logic                  jtag_tdi,
   output logic                  jtag_tdo,
   output logic                  jtag_tdo_en,
   input  logic                  debug_locked,      // Sampled only during rst
   input  lifecycle_t            device_lifecycle,  // Sampled only during rst
   output logic                  uncore_dmi_reg_en,
   output logic                  uncore_dmi_reg_wr_en,
   input  logic [DMI_DATA_W-1:0] uncore_dmi_reg_rdata,
   output logic [DMI_ADDR_W-1:0] uncore_dmi_reg_addr,
   output logic [DMI_DATA_W-1:0] uncore_dmi_reg_wdata,
   output logic                  dmi_reg_en_pre
);

   logic                  dmi_update;
   logic [DMI_ADDR_W-1:0] dmi_scan_addr;
   logic [DMI_DATA_W-1:0] dmi_scan_data;
   dmi_op_t               dmi_scan_op;
   logic [DMI_SCAN_W-1:0] dmi_capture_word;
   logic                  dmi_reg_en;
   logic                  dmi_reg_wr_en;
   logic [DMI_ADDR_W-1:0] dmi_reg_addr;
   logic [DMI_DATA_W-1:0] dmi_reg_wdata;
   logic [DMI_DATA_W-1:0] dmi_reg_rdata;
   logic                  core_reg_en;
   logic                  core_reg_wr_en;
   logic [DMI_DATA_W-1:0] core_reg_rdata;

   dbg_jtag_tap #(.IDCODE(IDCODE)) u_tap (
      .clk, .rst, .jtag_tck, .jtag_tms, .jtag_tdi, .jtag_tdo, .jtag_tdo_en,
      .dmi_capture_word, .dmi_update, .dmi_scan_addr, .dmi_scan_data, .dmi_scan_op
   );

   dbg_dmi_access u_dmi_access (
      .clk, .rst, .dmi_update, .dmi_scan_addr, .dmi_scan_data, .dmi_scan_op,
      .dmi_reg_rdata, .dmi_reg_en, .dmi_reg_wr_en, .dmi_reg_addr, .dmi_reg_wdata,
      .dmi_capture_word
   );

   dbg_access_gate u_gate (
      .clk, .rst, .debug_locked, .device_lifecycle, .dmi_reg_en, .dmi_reg_wr_en,
      .dmi_reg_addr, .core_reg_rdata, .uncore_dmi_reg_rdata, .core_reg_en,
      .core_reg_wr_en, .uncore_dmi_reg_en, .uncore_dmi_reg_wr_en, .dmi_reg_en_pre,
      .dmi_reg_rdata
   );

   dbg_core_regs #(.CORE_REG_COUNT(CORE_REG_COUNT)) u_core_regs (
      .clk, .rst, .core_reg_en, .core_reg_wr_en, .dmi_reg_addr, .dmi_reg_wdata,
      .core_reg_rdata
   );

   // Address and data go out unqualified, enables carry the gating
   assign uncore_dmi_reg_addr  = dmi_reg_addr;
   assign uncore_dmi_reg_wdata = dmi_reg_wdata;

endmodule

/* hdl/dbg_jtag_pkg.sv */
/*
 * JTAG TAP state encoding, instruction opcodes and DMI scan layout
 * shared by the TAP, the DMI access stage and the gate
 */

package dbg_jtag_pkg;

   // DMI scan register fields, LSB first: op, data, addr
   localparam int DMI_ADDR_W = 7;
   localparam int DMI_DATA_W = 32;
   localparam int DMI_OP_W   = 2;
   localparam int DMI_SCAN_W = DMI_ADDR_W + DMI_DATA_W + DMI_OP_W;

   // abits = 7 in [9:4], version 1 in [3:0]
   localparam logic [31:0] DTMCS_VALUE = {22'd0, 6'(DMI_ADDR_W), 4'd1};

   // Standard TAP controller encoding
   typedef enum logic [3:0] {
      EXIT2_DR         = 4'h0,
      EXIT1_DR         = 4'h1,
      SHIFT_DR         = 4'h2,
      PAUSE_DR         = 4'h3,
      SELECT_IR_SCAN   = 4'h4,
      UPDATE_DR        = 4'h5,
      CAPTURE_DR       = 4'h6,
      SELECT_DR_SCAN   = 4'h7,
      EXIT2_IR         = 4'h8,
      EXIT1_IR         = 4'h9,
      SHIFT_IR         = 4'hA,
      PAUSE_IR         = 4'hB,
      RUN_TEST_IDLE    = 4'hC,
      UPDATE_IR        = 4'hD,
      CAPTURE_IR       = 4'hE,
      TEST_LOGIC_RESET = 4'hF
   } tap_state_t;

   typedef enum logic [4:0] {
      IR_IDCODE = 5'h01,
      IR_DTMCS  = 5'h10,
      IR_DMI    = 5'h11,
      IR_BYPASS = 5'h1F
   } ir_opcode_t;

   typedef enum logic [DMI_OP_W-1:0] {
      DMI_NOP   = 2'd0,
      DMI_READ  = 2'd1,
      DMI_WRITE = 2'd2   // Value 3 reserved
   } dmi_op_t;

endpackage

/* hdl/dbg_jtag_tap.sv */
/*
 * JTAG TAP oversampled in the clk domain: pin synchronizers,
 * TAP controller, IR and DR shift paths for IDCODE, DTMCS, DMI
 * and BYPASS, TDO output and the DMI update pulse
 */

`timescale 1ns/1ns

module dbg_jtag_tap
   import dbg_jtag_pkg::*;
#(
   parameter logic [31:0] IDCODE = 32'h1000_0cd3
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  jtag_tck,
   input  logic                  jtag_tms,
   input  logic                  jtag_tdi,
   output logic                  jtag_tdo,
   output logic                  jtag_tdo_en,
   input  logic [DMI_SCAN_W-1:0] dmi_capture_word,  // Loaded at Capture-DR
   output logic                  dmi_update,        // One cycle per DMI Update-DR
   output logic [DMI_ADDR_W-1:0] dmi_scan_addr,
   output logic [DMI_DATA_W-1:0] dmi_scan_data,
   output dmi_op_t               dmi_scan_op
);

   localparam int IR_W = $bits(ir_opcode_t);

   logic [1:0]            tck_sync;
   logic [1:0]            tms_sync;
   logic [1:0]            tdi_sync;
   logic                  tck_q;
   logic                  tck_rise;
   logic                  tck_fall;
   logic                  tms;
   logic                  tdi;
   tap_state_t            state;
   tap_state_t            state_next;
   ir_opcode_t            ir;
   logic [IR_W-1:0]       ir_shift;
   logic [DMI_SCAN_W-1:0] dr_shift;
   logic [DMI_SCAN_W-1:0] dr_capture;
   logic [DMI_SCAN_W-1:0] dr_shifted;

   //*************************************************
   // Pin synchronizers and TCK edge detect
   //*************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         tck_sync <= '0;
         tms_sync <= '1;   // TMS idles high
         tdi_sync <= '0;
         tck_q    <= 1'b0;
      end else begin
         tck_sync <= {tck_sync[0], jtag_tck};
         tms_sync <= {tms_sync[0], jtag_tms};
         tdi_sync <= {tdi_sync[0], jtag_tdi};
         tck_q    <= tck_sync[1];
      end
   end

   assign tck_rise = tck_sync[1] & ~tck_q;
   assign tck_fall = ~tck_sync[1] & tck_q;
   assign tms      = tms_sync[1];   // Sampled along with the TCK edge
   assign tdi      = tdi_sync[1];

   //*************************************************
   // TAP controller
   //*************************************************

   always_comb begin
      case (state)
         TEST_LOGIC_RESET: state_next = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
         RUN_TEST_IDLE:    state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
         SELECT_DR_SCAN:   state_next = tms ? SELECT_IR_SCAN : CAPTURE_DR;
         CAPTURE_DR:       state_next = tms ? EXIT1_DR : SHIFT_DR;
         SHIFT_DR:         state_next = tms ? EXIT1_DR : SHIFT_DR;
         EXIT1_DR:         state_next = tms ? UPDATE_DR : PAUSE_DR;
         PAUSE_DR:         state_next = tms ? EXIT2_DR : PAUSE_DR;
         EXIT2_DR:         state_next = tms ? UPDATE_DR : SHIFT_DR;
         UPDATE_DR:        state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
         SELECT_IR_SCAN:   state_next = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
         CAPTURE_IR:       state_next = tms ? EXIT1_IR : SHIFT_IR;
         SHIFT_IR:         state_next = tms ? EXIT1_IR : SHIFT_IR;
         EXIT1_IR:         state_next = tms ? UPDATE_IR : PAUSE_IR;
         PAUSE_IR:         state_next = tms ? EXIT2_IR : PAUSE_IR;
         EXIT2_IR:         state_next = tms ? UPDATE_IR : SHIFT_IR;
         UPDATE_IR:        state_next = tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
         default:          state_next = TEST_LOGIC_RESET;
      endcase
   end

   // Capture value per selected data register
   always_comb begin
      case (ir)
         IR_IDCODE: dr_capture = DMI_SCAN_W'(IDCODE);
         IR_DTMCS:  dr_capture = DMI_SCAN_W'(DTMCS_VALUE);
         IR_DMI:    dr_capture = dmi_capture_word;
         default:   dr_capture = '0;   // BYPASS and unknown opcodes
      endcase
   end

   // TDI enters at the top bit of the selected register
   always_comb begin
      dr_shifted = dr_shift >> 1;
      case (ir)
         IR_IDCODE, IR_DTMCS: dr_shifted[31] = tdi;
         IR_DMI:              dr_shifted[DMI_SCAN_W-1] = tdi;
         default:             dr_shifted[0] = tdi;   // One-bit bypass
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= TEST_LOGIC_RESET;
         ir       <= IR_IDCODE;
         ir_shift <= '0;
         dr_shift <= '0;
      end else if (tck_rise) begin
         state <= state_next;
         case (state)
            CAPTURE_IR: ir_shift <= IR_W'(1);
            SHIFT_IR:   ir_shift <= {tdi, ir_shift[IR_W-1:1]};
            CAPTURE_DR: dr_shift <= dr_capture;
            SHIFT_DR:   dr_shift <= dr_shifted;
            default:    ;
         endcase
         if (state_next == TEST_LOGIC_RESET) begin
            ir <= IR_IDCODE;
         end else if (state_next == UPDATE_IR) begin
            ir <= ir_opcode_t'(ir_shift);
         end
      end
   end

   //*************************************************
   // TDO and DMI update
   //*************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         jtag_tdo    <= 1'b0;
         jtag_tdo_en <= 1'b0;
      end else if (tck_fall) begin
         jtag_tdo_en <= (state == SHIFT_IR) || (state == SHIFT_DR);
         jtag_tdo    <= (state == SHIFT_IR) ? ir_shift[0] : dr_shift[0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dmi_update <= 1'b0;
      end else begin
         dmi_update <= tck_rise && (state_next == UPDATE_DR) && (ir == IR_DMI);
      end
   end

   // Shift register stays put from Exit1-DR until the next capture
   assign dmi_scan_op   = dmi_op_t'(dr_shift[DMI_OP_W-1:0]);
   assign dmi_scan_data = dr_shift[DMI_OP_W +: DMI_DATA_W];
   assign dmi_scan_addr = dr_shift[DMI_OP_W+DMI_DATA_W +: DMI_ADDR_W];

endmodule

/* hdl/dbg_security_pkg.sv */
/*
 * Security state definitions for debug access gating:
 * device lifecycle encoding and the uncore register aperture
 */

package dbg_security_pkg;

   //*************************************************
   // Lifecycle
   //*************************************************

   typedef enum logic [1:0] {
      DEVICE_UNPROVISIONED = 2'b00,
      DEVICE_MANUFACTURING = 2'b01,
      DEVICE_PRODUCTION    = 2'b11
   } lifecycle_t;

   //*************************************************
   // DMI address map
   //*************************************************

   // Core side owns 0x00-0x4F, uncore owns 0x50-0x7F
   localparam logic [6:0] UNCORE_APERTURE_BASE = 7'h50;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the debug access testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_dbg_dmi_top -f dbg_dmi_top.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_dbg_dmi_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
   echo "PASS"
   exit 0
fi
echo "FAIL"
exit 1

/* include/tb_jtag_tasks.svh */
/*
 * JTAG bit-banging tasks for one TCK period, TAP reset through TMS,
 * IR scan and DR scan, each starting and ending in Run-Test/Idle
 */

`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

   // One TCK period with each level held 4 clk cycles
   task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
      jtag_tck = 1'b0;
      jtag_tms = tms;
      jtag_tdi = tdi;
      repeat (4) @(negedge clk);
      tdo      = jtag_tdo;   // Registered on the synchronized fall a cycle earlier
      jtag_tck = 1'b1;
      repeat (4) @(negedge clk);
   endtask

   task automatic tap_reset();
      logic tdo;
      repeat (5) tck_cycle(1'b1, 1'b0, tdo);   // Test-Logic-Reset from any state
      tck_cycle(1'b0, 1'b0, tdo);
   endtask

   task automatic ir_scan(input ir_opcode_t op);
      logic tdo;
      int   i;
      tck_cycle(1'b1, 1'b0, tdo);   // Select-DR-Scan
      tck_cycle(1'b1, 1'b0, tdo);   // Select-IR-Scan
      tck_cycle(1'b0, 1'b0, tdo);   // Capture-IR
      tck_cycle(1'b0, 1'b0, tdo);   // Shift-IR
      for (i = 0; i < $bits(ir_opcode_t); i++) begin
         tck_cycle(i == $bits(ir_opcode_t) - 1, op[i], tdo);
         check_value("jtag_tdo_en", 64'(jtag_tdo_en), 64'(1));
      end
      tck_cycle(1'b1, 1'b0, tdo);   // Update-IR
      tck_cycle(1'b0, 1'b0, tdo);
      check_value("jtag_tdo_en", 64'(jtag_tdo_en), 64'(0));
   endtask

   // Shifts LSB first and dout[i] holds the TDO bit seen before the i-th shift
   task automatic dr_scan(input int len, input logic [63:0] din, output logic [63:0] dout);
      logic tdo;
      int   i;
      dout = '0;
      tck_cycle(1'b1, 1'b0, tdo);   // Select-DR-Scan
      tck_cycle(1'b0, 1'b0, tdo);   // Capture-DR
      tck_cycle(1'b0, 1'b0, tdo);   // Shift-DR
      for (i = 0; i < len; i++) begin
         tck_cycle(i == len - 1, din[i], tdo);
         dout[i] = tdo;
         check_value("jtag_tdo_en", 64'(jtag_tdo_en), 64'(1));
      end
      tck_cycle(1'b1, 1'b0, tdo);   // Update-DR
      tck_cycle(1'b0, 1'b0, tdo);
      check_value("jtag_tdo_en", 64'(jtag_tdo_en), 64'(0));
   endtask

`endif

/* verif/tb_dbg_dmi_top.sv */
/*
 * Testbench for the debug access top level with clock, reset, watchdog,
 * register model with uncore responder, checks and random DMI traffic
 */

`timescale 1ns/1ns

module tb_dbg_dmi_top
   import dbg_jtag_pkg::*;
   import dbg_security_pkg::*;
();

   localparam logic [31:0] TB_IDCODE      = 32'h1000_0cd3;
   localparam int          CORE_REG_COUNT = 16;
   localparam int          N_CORE         = 40;
   localparam int          N_UNCORE       = 16;
   localparam int          N_LATE         = 8;
   // At most two scans per access plus setup scans, each TCK 8 clk of 8 ns
   localparam int          MAX_SCANS      = 2 * (3 * N_CORE + 2 * N_UNCORE + 2 * N_LATE) + 20;
   localparam int          WATCHDOG_NS    = MAX_SCANS * (DMI_SCAN_W + 8) * 8 * 8 * 2;

   logic        clk;
   logic        rst = 1'b1;
   logic        jtag_tck = 1'b0;
   logic        jtag_tms = 1'b1;
   logic        jtag_tdi = 1'b0;
   logic        jtag_tdo;
   logic        jtag_tdo_en;
   logic        debug_locked = 1'b0;
   lifecycle_t  device_lifecycle = DEVICE_PRODUCTION;
   logic        uncore_dmi_reg_en;
   logic        uncore_dmi_reg_wr_en;
   logic [31:0] uncore_dmi_reg_rdata = '0;
   logic [6:0]  uncore_dmi_reg_addr;
   logic [31:0] uncore_dmi_reg_wdata;
   logic        dmi_reg_en_pre;
   logic        allowed_model;
   logic [31:0] core_model [128];
   int          pre_count = 0;
   int          uncore_count = 0;
   logic [6:0]  last_addr;
   logic [31:0] last_wdata;
   logic        last_wr;
   logic [63:0] dout;
   logic [63:0] pattern;

   dbg_dmi_top #(.IDCODE(TB_IDCODE), .CORE_REG_COUNT(CORE_REG_COUNT)) u_dut (
      .clk(clk), .rst(rst), .jtag_tck(jtag_tck), .jtag_tms(jtag_tms), .jtag_tdi(jtag_tdi),
      .jtag_tdo(jtag_tdo), .jtag_tdo_en(jtag_tdo_en), .debug_locked(debug_locked),
      .device_lifecycle(device_lifecycle), .uncore_dmi_reg_en(uncore_dmi_reg_en),
      .uncore_dmi_reg_wr_en(uncore_dmi_reg_wr_en), .uncore_dmi_reg_rdata(uncore_dmi_reg_rdata),
      .uncore_dmi_reg_addr(uncore_dmi_reg_addr), .uncore_dmi_reg_wdata(uncore_dmi_reg_wdata),
      .dmi_reg_en_pre(dmi_reg_en_pre)
   );

   `include "tb_jtag_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the test sequence completed");
      $display("Finished with errors");
      $fatal(1, "Simulation timed out");
   end

   //*************************************************
   // Model and uncore responder
   //*************************************************

   // Uncore read data is the inverted address repeated
   function automatic logic [31:0] uncore_value(input logic [6:0] addr);
      return ~32'({5{addr}});
   endfunction

   function automatic logic [31:0] expected_read(input logic [6:0] addr);
      if (!allowed_model) return '0;
      if (addr >= 7'h50) return uncore_value(addr);
      if (int'(addr) < CORE_REG_COUNT) return core_model[addr];
      return '0;   // Unimplemented core addresses
   endfunction

   always @(negedge clk) begin
      uncore_dmi_reg_rdata <= uncore_value(uncore_dmi_reg_addr);
      if (!rst && dmi_reg_en_pre) begin
         pre_count <= pre_count + 1;
      end
      if (!rst && uncore_dmi_reg_en) begin
         uncore_count <= uncore_count + 1;
         last_addr    <= uncore_dmi_reg_addr;
         last_wdata   <= uncore_dmi_reg_wdata;
         last_wr      <= uncore_dmi_reg_wr_en;
      end
   end

   //*************************************************
   // Checks and access tasks
   //*************************************************

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
         $display("Finished with errors");
         $fatal(1, "Value mismatch");
      end
   endtask

   task automatic apply_reset(input logic locked, input lifecycle_t lifecycle);
      int i;
      rst              = 1'b1;
      debug_locked     = locked;
      device_lifecycle = lifecycle;
      jtag_tck         = 1'b0;
      jtag_tms         = 1'b1;
      jtag_tdi         = 1'b0;
      repeat (3) @(negedge clk);
      rst           = 1'b0;
      allowed_model = !locked || (lifecycle == DEVICE_MANUFACTURING);
      for (i = 0; i < 128; i++) begin
         core_model[i] = '0;
      end
      check_value("jtag_tdo_en", 64'(jtag_tdo_en), 64'(0));
      check_value("uncore_dmi_reg_en", 64'(uncore_dmi_reg_en), 64'(0));
      tap_reset();
   endtask

   // One DMI op with a NOP scan after each read to return its data
   task automatic dmi_access(input dmi_op_t op, input logic [6:0] addr, input logic [31:0] data);
      logic [63:0] scan_out;
      int          pre_before;
      int          unc_before;
      logic        to_uncore;
      pre_before = pre_count;
      unc_before = uncore_count;
      to_uncore  = allowed_model && (addr >= 7'h50);
      dr_scan(DMI_SCAN_W, {23'd0, addr, data, op}, scan_out);
      check_value("dmi_reg_en_pre pulses", 64'(pre_count), 64'(pre_before + 1));
      check_value("uncore_dmi_reg_en pulses", 64'(uncore_count),
                  64'(unc_before + int'(to_uncore)));
      if (to_uncore) begin
         check_value("uncore_dmi_reg_addr", 64'(last_addr), 64'(addr));
         check_value("uncore_dmi_reg_wr_en", 64'(last_wr), 64'(op == DMI_WRITE));
         if (op == DMI_WRITE) begin
            check_value("uncore_dmi_reg_wdata", 64'(last_wdata), 64'(data));
         end
      end
      if (op == DMI_WRITE) begin
         if (allowed_model && int'(addr) < CORE_REG_COUNT) begin
            core_model[addr] = data;
         end
      end else begin
         dr_scan(DMI_SCAN_W, 64'(0), scan_out);
         check_value("dmi_reg_en_pre pulses", 64'(pre_count), 64'(pre_before + 1));
         check_value("dmi read data", 64'(scan_out[33:2]), 64'(expected_read(addr)));
         check_value("dmi capture addr", 64'(scan_out[40:34]), 64'(addr));
      end
   endtask

   task automatic run_random(input int count, input logic with_uncore);
      dmi_op_t    op;
      logic [6:0] addr;
      int         n;
      for (n = 0; n < count; n++) begin
         op = ($urandom % 2 == 0) ? DMI_READ : DMI_WRITE;
         if (with_uncore && ($urandom % 3 == 0)) begin
            addr = 7'h50 + 7'($urandom % 48);
         end else if ($urandom % 5 == 0) begin
            addr = 7'($urandom % 80);   // Anywhere in the core aperture
         end else begin
            addr = 7'($urandom % 20);
         end
         dmi_access(op, addr, $urandom);
      end
   endtask

   //*************************************************
   // Test sequence
   //*************************************************

   initial begin
      void'($urandom(32'hd49d_5746));
      @(negedge clk);

      // Unlocked production part
      apply_reset(1'b0, DEVICE_PRODUCTION);
      dr_scan(32, 64'(0), dout);
      check_value("IDCODE", dout, 64'(TB_IDCODE));
      ir_scan(IR_DTMCS);
      dr_scan(32, 64'(0), dout);
      check_value("DTMCS", dout, 64'h71);   // abits 7 and version 1
      ir_scan(IR_BYPASS);
      pattern = 64'($urandom % 65536);
      dr_scan(16, pattern, dout);
      check_value("BYPASS", dout, 64'({pattern[14:0], 1'b0}));
      ir_scan(IR_DMI);
      run_random(N_CORE, 1'b0);
      run_random(N_UNCORE, 1'b1);
      debug_locked = 1'b1;   // Ignored until the next reset
      run_random(N_LATE, 1'b1);

      // Locked production part
      apply_reset(1'b1, DEVICE_PRODUCTION);
      ir_scan(IR_DMI);
      run_random(N_CORE, 1'b1);
      debug_locked     = 1'b0;
      device_lifecycle = DEVICE_MANUFACTURING;
      run_random(N_LATE, 1'b1);

      // Locked part in manufacturing
      apply_reset(1'b1, DEVICE_MANUFACTURING);
      ir_scan(IR_DMI);
      run_random(N_CORE, 1'b0);
      run_random(N_UNCORE, 1'b1);

      $display("Finished with no errors");
      $finish;
   end

endmodule
